// ==== compile.f ====
design/fabric_pkg.sv
design/reset_sequencer.sv
design/fabric_ctrl.sv
design/dma_upsizer.sv
design/sdc_downsizer.sv
design/fpga_fabric_top.sv
tests/fabric_assertions.sv
tests/fabric_tb.sv

// ==== design/dma_upsizer.sv ====
// 32-to-64 converter on the DMA path, single beats only
// Request path is combinational; address bit 2 picks the lane
// The lane is latched at acceptance to select read data on return

`timescale 1ns/100ps

module dma_upsizer (
  input  logic                 cpu_clk_i,
  input  logic                 bus_rst_i,
  // 32-bit DMA side
  input  fabric_pkg::dma_req_t up_req_i,
  output logic                 up_ready_o,
  output fabric_pkg::dma_rsp_t up_rsp_o,
  // 64-bit fabric side
  output fabric_pkg::fab_req_t dn_req_o,
  input  logic                 dn_ready_i,
  input  fabric_pkg::fab_rsp_t dn_rsp_i
);

  logic hi_lane;
  logic lane_q;

  assign hi_lane = up_req_i.addr[2];

  // Data on both lanes, strobes only on the addressed one
  assign dn_req_o = '{valid: up_req_i.valid,
                      write: up_req_i.write,
                      addr:  up_req_i.addr,
                      data:  {2{up_req_i.data}},
                      strb:  hi_lane ? {up_req_i.strb, 4'b0000} : {4'b0000, up_req_i.strb}};

  assign up_ready_o = dn_ready_i;

  always_ff @(posedge cpu_clk_i) begin
    if (bus_rst_i) begin
      lane_q <= 1'b0;
    end else if (up_req_i.valid && dn_ready_i) begin
      lane_q <= hi_lane;
    end
  end

  assign up_rsp_o = '{valid: dn_rsp_i.valid,
                      err:   dn_rsp_i.err,
                      data:  lane_q ? dn_rsp_i.data[63:32] : dn_rsp_i.data[31:0]};

endmodule

// ==== design/fabric_ctrl.sv ====
// Two-master arbiter and address decoder standing in for the crossbar
// Masters: CPU (64-bit) and DMA (already upsized to 64-bit)
// Targets: external memory and the SD-card register path
// One transaction at a time across the whole fabric, round robin grant
// Addresses outside both windows get a local error response 2 cycles
// after acceptance with no downstream request

`timescale 1ns/100ps

module fabric_ctrl #(
  parameter int                MEM_ADDR_BITS = fabric_pkg::MEM_ADDR_BITS,
  parameter fabric_pkg::addr_t SDC_BASE      = fabric_pkg::SDC_BASE
) (
  input  logic                 cpu_clk_i,
  input  logic                 bus_rst_i,
  // CPU master
  input  fabric_pkg::fab_req_t cpu_req_i,
  output logic                 cpu_ready_o,
  output fabric_pkg::fab_rsp_t cpu_rsp_o,
  // DMA master
  input  fabric_pkg::fab_req_t dma_req_i,
  output logic                 dma_ready_o,
  output fabric_pkg::fab_rsp_t dma_rsp_o,
  // Memory target
  output fabric_pkg::fab_req_t mem_req_o,
  input  logic                 mem_ready_i,
  input  fabric_pkg::fab_rsp_t mem_rsp_i,
  // SD-card target
  output fabric_pkg::fab_req_t sdc_req_o,
  input  logic                 sdc_ready_i,
  input  fabric_pkg::fab_rsp_t sdc_rsp_i
);

  localparam int SDC_WIN_BITS = $bits(fabric_pkg::sdc_addr_t);

  fabric_pkg::ctrl_state_t state_q;
  fabric_pkg::ctrl_state_t state_d;
  fabric_pkg::fab_req_t    sel_req;
  fabric_pkg::fab_req_t    req_q;
  fabric_pkg::fab_rsp_t    tgt_rsp;
  fabric_pkg::data64_t     rsp_data_q;

  logic grant_dma;
  logic accept;
  logic hit_mem;
  logic hit_sdc;
  logic last_dma_q;
  logic gnt_dma_q;
  logic to_mem_q;
  logic to_sdc_q;
  logic no_target;
  logic tgt_ready;
  logic rsp_hit;
  logic rsp_err_q;

  // --------------------------------------------------
  // Arbitration and decode
  // --------------------------------------------------

  // DMA wins when alone, or when both ask and CPU went last
  assign grant_dma = dma_req_i.valid & (~cpu_req_i.valid | ~last_dma_q);
  assign accept    = (state_q == fabric_pkg::IDLE) & (cpu_req_i.valid | dma_req_i.valid);

  assign cpu_ready_o = (state_q == fabric_pkg::IDLE) & ~bus_rst_i &
                       cpu_req_i.valid & ~grant_dma;
  assign dma_ready_o = (state_q == fabric_pkg::IDLE) & ~bus_rst_i & grant_dma;

  assign sel_req = grant_dma ? dma_req_i : cpu_req_i;
  assign hit_mem = (sel_req.addr >> MEM_ADDR_BITS) == '0;
  assign hit_sdc = sel_req.addr[31:SDC_WIN_BITS] == SDC_BASE[31:SDC_WIN_BITS];

  always_ff @(posedge cpu_clk_i) begin
    if (bus_rst_i) begin
      last_dma_q <= 1'b1;
      gnt_dma_q  <= 1'b0;
      to_mem_q   <= 1'b0;
      to_sdc_q   <= 1'b0;
    end else if (accept) begin
      last_dma_q <= grant_dma;
      gnt_dma_q  <= grant_dma;
      to_mem_q   <= hit_mem;
      to_sdc_q   <= hit_sdc & ~hit_mem;
    end
  end

  // Request payload, held until the target takes it
  always_ff @(posedge cpu_clk_i) begin
    if (accept) begin
      req_q <= sel_req;
    end
  end

  // --------------------------------------------------
  // Target side
  // --------------------------------------------------
  assign no_target = ~to_mem_q & ~to_sdc_q;
  assign tgt_ready = to_mem_q ? mem_ready_i : (to_sdc_q & sdc_ready_i);
  assign tgt_rsp   = to_mem_q ? mem_rsp_i : sdc_rsp_i;

  // A response may come with the ready, so ISSUE takes it as well
  assign rsp_hit = tgt_rsp.valid & ~no_target &
                   ((state_q == fabric_pkg::ISSUE) | (state_q == fabric_pkg::WAIT_RSP));

  always_comb begin
    mem_req_o       = req_q;
    mem_req_o.valid = (state_q == fabric_pkg::ISSUE) & to_mem_q;
    sdc_req_o       = req_q;
    sdc_req_o.valid = (state_q == fabric_pkg::ISSUE) & to_sdc_q;
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      fabric_pkg::IDLE: begin
        if (accept) begin
          state_d = fabric_pkg::ISSUE;
        end
      end
      fabric_pkg::ISSUE: begin
        if (no_target || rsp_hit) begin
          state_d = fabric_pkg::RESPOND;
        end else if (tgt_ready) begin
          state_d = fabric_pkg::WAIT_RSP;
        end
      end
      fabric_pkg::WAIT_RSP: begin
        if (rsp_hit) begin
          state_d = fabric_pkg::RESPOND;
        end
      end
      default: state_d = fabric_pkg::IDLE;
    endcase
  end

  always_ff @(posedge cpu_clk_i) begin
    if (bus_rst_i) begin
      state_q <= fabric_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Response capture, local decode error or target response
  always_ff @(posedge cpu_clk_i) begin
    if ((state_q == fabric_pkg::ISSUE) && no_target) begin
      rsp_err_q  <= 1'b1;
      rsp_data_q <= '0;
    end else if (rsp_hit) begin
      rsp_err_q  <= tgt_rsp.err;
      rsp_data_q <= tgt_rsp.data;
    end
  end

  // Pulse back to whichever master owns the transaction
  assign cpu_rsp_o = '{valid: (state_q == fabric_pkg::RESPOND) & ~gnt_dma_q,
                       err:   rsp_err_q,
                       data:  rsp_data_q};
  assign dma_rsp_o = '{valid: (state_q == fabric_pkg::RESPOND) & gnt_dma_q,
                       err:   rsp_err_q,
                       data:  rsp_data_q};

endmodule

// ==== design/fabric_pkg.sv ====
// Shared types and constants for the single-clock bus fabric
// Memory window starts at address 0; SD-card window is 256 bytes
// Structs carry one request or one response channel, no burst or ID
// fields; one transaction outstanding per master

package fabric_pkg;

  // Widths that carry a meaning
  typedef logic [31:0] addr_t;
  typedef logic [63:0] data64_t;
  typedef logic [31:0] data32_t;
  typedef logic [7:0]  strb8_t;
  typedef logic [3:0]  strb4_t;
  typedef logic [7:0]  sdc_addr_t;

  // Default address map
  localparam int    MEM_ADDR_BITS = 28;
  localparam addr_t SDC_BASE      = 32'h1001_3000;

  // --------------------------------------------------
  // Request and response channels
  // --------------------------------------------------
  typedef struct packed {
    logic    valid;
    logic    write;
    addr_t   addr;
    data64_t data;
    strb8_t  strb;
  } fab_req_t;

  typedef struct packed {
    logic    valid;
    logic    err;
    data64_t data;
  } fab_rsp_t;

  typedef struct packed {
    logic    valid;
    logic    write;
    addr_t   addr;
    data32_t data;
    strb4_t  strb;
  } dma_req_t;

  typedef struct packed {
    logic    valid;
    logic    err;
    data32_t data;
  } dma_rsp_t;

  typedef struct packed {
    logic      valid;
    logic      write;
    sdc_addr_t addr;
    data32_t   data;
    strb4_t    strb;
  } sdc_req_t;

  typedef struct packed {
    logic    valid;
    logic    err;
    data32_t data;
  } sdc_rsp_t;

  // Fabric controller FSM
  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT_RSP,
    RESPOND
  } ctrl_state_t;

endpackage

// ==== design/fpga_fabric_top.sv ====
// Bus fabric of the FPGA top level, single clock domain
// Memory and SD-card register block are external ports
// Valid/ready requests, pulsed responses without back-pressure,
// one outstanding transaction per master
// bus_rst_o resets every block below and is exported for the targets

`timescale 1ns/100ps

module fpga_fabric_top #(
  parameter int                MEM_ADDR_BITS     = fabric_pkg::MEM_ADDR_BITS,
  parameter fabric_pkg::addr_t SDC_BASE          = fabric_pkg::SDC_BASE,
  parameter int                RESET_HOLD_CYCLES = 16
) (
  input  logic                 cpu_clk_i,
  input  logic                 rst_i,
  input  logic                 calib_done_i,
  input  logic                 aux_rst_i,
  output logic                 bus_rst_o,
  // Processor port
  input  fabric_pkg::fab_req_t cpu_req_i,
  output logic                 cpu_ready_o,
  output fabric_pkg::fab_rsp_t cpu_rsp_o,
  // SD-card DMA port
  input  fabric_pkg::dma_req_t dma_req_i,
  output logic                 dma_ready_o,
  output fabric_pkg::dma_rsp_t dma_rsp_o,
  // External memory
  output fabric_pkg::fab_req_t mem_req_o,
  input  logic                 mem_ready_i,
  input  fabric_pkg::fab_rsp_t mem_rsp_i,
  // SD-card register window
  output fabric_pkg::sdc_req_t sdc_req_o,
  input  logic                 sdc_ready_i,
  input  fabric_pkg::sdc_rsp_t sdc_rsp_i
);

  logic                 bus_rst;
  fabric_pkg::fab_req_t dma_fab_req;
  logic                 dma_fab_ready;
  fabric_pkg::fab_rsp_t dma_fab_rsp;
  fabric_pkg::fab_req_t sdc_fab_req;
  logic                 sdc_fab_ready;
  fabric_pkg::fab_rsp_t sdc_fab_rsp;

  assign bus_rst_o = bus_rst;

  reset_sequencer #(
    .RESET_HOLD_CYCLES(RESET_HOLD_CYCLES)
  ) reset_sequencer_i (
    .cpu_clk_i   (cpu_clk_i),
    .rst_i       (rst_i),
    .calib_done_i(calib_done_i),
    .aux_rst_i   (aux_rst_i),
    .bus_rst_o   (bus_rst)
  );

  // DMA onto the 64-bit fabric
  dma_upsizer dma_upsizer_i (
    .cpu_clk_i (cpu_clk_i),
    .bus_rst_i (bus_rst),
    .up_req_i  (dma_req_i),
    .up_ready_o(dma_ready_o),
    .up_rsp_o  (dma_rsp_o),
    .dn_req_o  (dma_fab_req),
    .dn_ready_i(dma_fab_ready),
    .dn_rsp_i  (dma_fab_rsp)
  );

  fabric_ctrl #(
    .MEM_ADDR_BITS(MEM_ADDR_BITS),
    .SDC_BASE     (SDC_BASE)
  ) fabric_ctrl_i (
    .cpu_clk_i  (cpu_clk_i),
    .bus_rst_i  (bus_rst),
    .cpu_req_i  (cpu_req_i),
    .cpu_ready_o(cpu_ready_o),
    .cpu_rsp_o  (cpu_rsp_o),
    .dma_req_i  (dma_fab_req),
    .dma_ready_o(dma_fab_ready),
    .dma_rsp_o  (dma_fab_rsp),
    .mem_req_o  (mem_req_o),
    .mem_ready_i(mem_ready_i),
    .mem_rsp_i  (mem_rsp_i),
    .sdc_req_o  (sdc_fab_req),
    .sdc_ready_i(sdc_fab_ready),
    .sdc_rsp_i  (sdc_fab_rsp)
  );

  // SD-card registers are 32-bit only
  sdc_downsizer sdc_downsizer_i (
    .cpu_clk_i  (cpu_clk_i),
    .bus_rst_i  (bus_rst),
    .up_req_i   (sdc_fab_req),
    .up_ready_o (sdc_fab_ready),
    .up_rsp_o   (sdc_fab_rsp),
    .sdc_req_o  (sdc_req_o),
    .sdc_ready_i(sdc_ready_i),
    .sdc_rsp_i  (sdc_rsp_i)
  );

endmodule

// ==== design/reset_sequencer.sv ====
// Bus reset generation from the external reset, the auxiliary reset
// and memory calibration. All inputs are sampled on cpu_clk_i
// Bus reset is high combinationally while any source is active and
// stays high for RESET_HOLD_CYCLES cycles after the first cycle in
// which all sources are inactive. No input synchronizers here

`timescale 1ns/100ps

module reset_sequencer #(
  parameter int RESET_HOLD_CYCLES = 16
) (
  input  logic cpu_clk_i,
  input  logic rst_i,
  input  logic calib_done_i,
  input  logic aux_rst_i,
  output logic bus_rst_o
);

  localparam int CNT_W = $clog2(RESET_HOLD_CYCLES + 1) > 0 ?
                         $clog2(RESET_HOLD_CYCLES + 1) : 1;

  logic             src_active;
  logic [CNT_W-1:0] hold_cnt_q;

  // Any source keeps the bus in reset
  assign src_active = rst_i | aux_rst_i | ~calib_done_i;

  // Reload while a source is active, count down once all are clear
  always_ff @(posedge cpu_clk_i) begin
    if (src_active) begin
      hold_cnt_q <= CNT_W'(RESET_HOLD_CYCLES);
    end else if (hold_cnt_q != '0) begin
      hold_cnt_q <= hold_cnt_q - 1'b1;
    end
  end

  assign bus_rst_o = src_active | (hold_cnt_q != '0);

endmodule

// ==== design/sdc_downsizer.sv ====
// 64-to-32 converter in front of the SD-card register port
// No split transfers: a write whose strobes touch both lanes is
// rejected with an error one cycle later and never reaches the port
// The SD-card request is registered, one cycle behind the fabric
// Read data comes back copied into both 64-bit lanes

`timescale 1ns/100ps

module sdc_downsizer (
  input  logic                 cpu_clk_i,
  input  logic                 bus_rst_i,
  // 64-bit fabric side
  input  fabric_pkg::fab_req_t up_req_i,
  output logic                 up_ready_o,
  output fabric_pkg::fab_rsp_t up_rsp_o,
  // 32-bit SD-card register port
  output fabric_pkg::sdc_req_t sdc_req_o,
  input  logic                 sdc_ready_i,
  input  fabric_pkg::sdc_rsp_t sdc_rsp_i
);

  logic lo_any;
  logic hi_any;
  logic span;
  logic lane_hi;
  logic take;
  logic sdc_vld_q;
  logic sdc_write_q;
  logic err_q;

  fabric_pkg::sdc_addr_t sdc_addr_q;
  fabric_pkg::data32_t   sdc_data_q;
  fabric_pkg::strb4_t    sdc_strb_q;

  assign lo_any = |up_req_i.strb[3:0];
  assign hi_any = |up_req_i.strb[7:4];
  assign span   = up_req_i.write & lo_any & hi_any;

  // Writes follow the strobes, reads follow address bit 2
  assign lane_hi = up_req_i.write ? (hi_any | (~lo_any & up_req_i.addr[2])) :
                                    up_req_i.addr[2];

  // Nothing new while a request or an error is pending
  assign take = up_req_i.valid & ~sdc_vld_q & ~err_q;

  always_ff @(posedge cpu_clk_i) begin
    if (bus_rst_i) begin
      sdc_vld_q <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      err_q <= take & span;
      if (sdc_vld_q) begin
        if (sdc_ready_i) begin
          sdc_vld_q <= 1'b0;
        end
      end else if (take && !span) begin
        sdc_vld_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge cpu_clk_i) begin
    if (take) begin
      sdc_write_q <= up_req_i.write;
      sdc_addr_q  <= {up_req_i.addr[7:3], lane_hi, up_req_i.addr[1:0]};
      sdc_data_q  <= lane_hi ? up_req_i.data[63:32] : up_req_i.data[31:0];
      sdc_strb_q  <= lane_hi ? up_req_i.strb[7:4] : up_req_i.strb[3:0];
    end
  end

  assign sdc_req_o = '{valid: sdc_vld_q,
                       write: sdc_write_q,
                       addr:  sdc_addr_q,
                       data:  sdc_data_q,
                       strb:  sdc_strb_q};

  // A rejected request is consumed in the same cycle as its error
  assign up_ready_o = (sdc_vld_q & sdc_ready_i) | err_q;

  assign up_rsp_o = '{valid: sdc_rsp_i.valid | err_q,
                      err:   sdc_rsp_i.err | err_q,
                      data:  {2{sdc_rsp_i.data}}};

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the fabric testbench with Verilator, result from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module fabric_tb -o sim_fabric \
  && { ./obj_dir/sim_fabric > sim.log 2>&1 || true; } \
  && grep -qx "All checks passed" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

// ==== tests/fabric_assertions.sv ====
// Grant and forwarding rules of the fabric controller
// Bound into every fabric_ctrl instance, idle during bus reset

`timescale 1ns/100ps

module fabric_assertions (
  input logic                 cpu_clk_i,
  input logic                 bus_rst_i,
  input fabric_pkg::fab_req_t cpu_req_i,
  input fabric_pkg::fab_req_t dma_req_i,
  input logic                 cpu_ready_i,
  input logic                 dma_ready_i,
  input fabric_pkg::fab_rsp_t cpu_rsp_i,
  input fabric_pkg::fab_rsp_t dma_rsp_i,
  input fabric_pkg::fab_req_t mem_req_i,
  input fabric_pkg::fab_req_t sdc_req_i
);

  logic busy_q;

  // Outstanding from an accepted request until its response pulse
  always_ff @(posedge cpu_clk_i) begin
    if (bus_rst_i) begin
      busy_q <= 1'b0;
    end else if ((cpu_ready_i && cpu_req_i.valid) || (dma_ready_i && dma_req_i.valid)) begin
      busy_q <= 1'b1;
    end else if (cpu_rsp_i.valid || dma_rsp_i.valid) begin
      busy_q <= 1'b0;
    end
  end

  // One master granted at a time
  one_ready: assert property (@(posedge cpu_clk_i) disable iff (bus_rst_i)
    !(cpu_ready_i && dma_ready_i))
    else $error("cpu_ready_o and dma_ready_o high together");

  // One target addressed at a time
  one_target: assert property (@(posedge cpu_clk_i) disable iff (bus_rst_i)
    !(mem_req_i.valid && sdc_req_i.valid))
    else $error("mem_req_o and sdc_req_o valid together");

  // Nothing accepted while busy
  no_ready_busy: assert property (@(posedge cpu_clk_i) disable iff (bus_rst_i)
    busy_q |-> !(cpu_ready_i || dma_ready_i))
    else $error("ready high with a transaction outstanding");

endmodule

bind fabric_ctrl fabric_assertions fabric_assertions_i (
  .cpu_clk_i  (cpu_clk_i),
  .bus_rst_i  (bus_rst_i),
  .cpu_req_i  (cpu_req_i),
  .dma_req_i  (dma_req_i),
  .cpu_ready_i(cpu_ready_o),
  .dma_ready_i(dma_ready_o),
  .cpu_rsp_i  (cpu_rsp_o),
  .dma_rsp_i  (dma_rsp_o),
  .mem_req_i  (mem_req_o),
  .sdc_req_i  (sdc_req_o)
);

// ==== tests/fabric_tb.sv ====
// Directed testbench for the bus fabric top level
// Memory model: associative array, ready after a programmable delay,
// response one cycle after the ready. SD-card model: 64 registers,
// ready at once. Inputs change on falling edges only

`timescale 1ns/100ps

module fabric_tb;

  localparam int HOLD = 16;
  localparam int TMO  = 64;

  logic clk = 1'b0;
  logic rst_i;
  logic calib_done_i;
  logic aux_rst_i;
  logic bus_rst_o;

  fabric_pkg::fab_req_t cpu_req_i;
  logic                 cpu_ready_o;
  fabric_pkg::fab_rsp_t cpu_rsp_o;
  fabric_pkg::dma_req_t dma_req_i;
  logic                 dma_ready_o;
  fabric_pkg::dma_rsp_t dma_rsp_o;
  fabric_pkg::fab_req_t mem_req_o;
  logic                 mem_ready_i;
  fabric_pkg::fab_rsp_t mem_rsp_i;
  fabric_pkg::sdc_req_t sdc_req_o;
  logic                 sdc_ready_i;
  fabric_pkg::sdc_rsp_t sdc_rsp_i;

  int errors = 0;
  int checks = 0;
  logic [31:0] lfsr = 32'h468fe2e5;

  // Model state
  fabric_pkg::data64_t  mem_model [fabric_pkg::addr_t];
  fabric_pkg::data64_t  shadow [fabric_pkg::addr_t];
  fabric_pkg::data32_t  sdc_regs [64];
  fabric_pkg::data64_t  mem_rd;
  fabric_pkg::data32_t  sdc_rd;
  fabric_pkg::fab_req_t mem_last;
  fabric_pkg::sdc_req_t sdc_last;
  int  mem_delay = 0;
  int  mem_wait = 0;
  int  mem_vld_cycles = 0;
  int  sdc_vld_cycles = 0;
  time cpu_acc_t;
  time dma_acc_t;
  logic last_dma = 1'b1;

  always #2 clk = ~clk;

  fpga_fabric_top #(
    .MEM_ADDR_BITS    (fabric_pkg::MEM_ADDR_BITS),
    .SDC_BASE         (fabric_pkg::SDC_BASE),
    .RESET_HOLD_CYCLES(HOLD)
  ) dut_i (
    .cpu_clk_i(clk), .rst_i(rst_i), .calib_done_i(calib_done_i), .aux_rst_i(aux_rst_i),
    .bus_rst_o(bus_rst_o),
    .cpu_req_i(cpu_req_i), .cpu_ready_o(cpu_ready_o), .cpu_rsp_o(cpu_rsp_o),
    .dma_req_i(dma_req_i), .dma_ready_o(dma_ready_o), .dma_rsp_o(dma_rsp_o),
    .mem_req_o(mem_req_o), .mem_ready_i(mem_ready_i), .mem_rsp_i(mem_rsp_i),
    .sdc_req_o(sdc_req_o), .sdc_ready_i(sdc_ready_i), .sdc_rsp_i(sdc_rsp_i)
  );

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------

  // Galois LFSR, one step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      v    = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [63:0] merge64(input logic [63:0] old, input logic [63:0] nw,
                                          input logic [7:0] s);
    logic [63:0] r;
    for (int b = 0; b < 8; b++) begin
      r[b*8 +: 8] = s[b] ? nw[b*8 +: 8] : old[b*8 +: 8];
    end
    return r;
  endfunction

  function automatic logic [31:0] merge32(input logic [31:0] old, input logic [31:0] nw,
                                          input logic [3:0] s);
    return 32'(merge64(64'(old), 64'(nw), {4'b0000, s}));
  endfunction

  function automatic logic [31:0] reg_init(input int idx);
    return 32'hc0de_0000 | (32'(idx) << 2);
  endfunction

  function automatic logic [63:0] shadow_get(input logic [31:0] k);
    return shadow.exists(k) ? shadow[k] : 64'h0;
  endfunction

  task automatic expect_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  task automatic abort_on_timeout(input string what);
    errors++;
    $display("Timeout: %s", what);
    finish_run();
  endtask

  function automatic logic outputs_quiet();
    return !(cpu_ready_o || dma_ready_o || cpu_rsp_o.valid || dma_rsp_o.valid ||
             mem_req_o.valid || sdc_req_o.valid);
  endfunction

  // --------------------------------------------------
  // Target models
  // --------------------------------------------------
  always @(negedge clk) begin
    if (mem_ready_i) begin
      mem_ready_i = 1'b0;
      mem_rsp_i   = '{valid: 1'b1, err: 1'b0, data: mem_rd};
    end else begin
      mem_rsp_i = '0;
      if (mem_req_o.valid === 1'b1) begin
        mem_vld_cycles++;
        if (mem_wait >= mem_delay) begin
          mem_wait    = 0;
          mem_ready_i = 1'b1;
          mem_last    = mem_req_o;
          mem_rd      = mem_model.exists(mem_req_o.addr >> 3) ?
                        mem_model[mem_req_o.addr >> 3] : 64'h0;
          if (mem_req_o.write) begin
            mem_model[mem_req_o.addr >> 3] = merge64(mem_rd, mem_req_o.data, mem_req_o.strb);
            mem_rd = '0;
          end
        end else begin
          mem_wait++;
        end
      end
    end
  end

  always @(negedge clk) begin
    if (sdc_ready_i) begin
      sdc_ready_i = 1'b0;
      sdc_rsp_i   = '{valid: 1'b1, err: 1'b0, data: sdc_rd};
    end else begin
      sdc_rsp_i = '0;
      if (sdc_req_o.valid === 1'b1) begin
        sdc_vld_cycles++;
        sdc_ready_i = 1'b1;
        sdc_last    = sdc_req_o;
        sdc_rd      = sdc_regs[sdc_req_o.addr[7:2]];
        if (sdc_req_o.write) begin
          sdc_regs[sdc_req_o.addr[7:2]] = merge32(sdc_rd, sdc_req_o.data, sdc_req_o.strb);
          sdc_rd = '0;
        end
      end
    end
  end

  // --------------------------------------------------
  // Master transactions
  // --------------------------------------------------
  task automatic cpu_xfer(input logic wr, input logic [31:0] a, input logic [63:0] d,
                          input logic [7:0] s, output logic err, output logic [63:0] data,
                          output int lat);
    int  n;
    logic done;
    n    = 0;
    done = 1'b0;
    @(negedge clk);
    cpu_req_i = '{valid: 1'b1, write: wr, addr: a, data: d, strb: s};
    while (!done) begin
      #1;
      if (cpu_ready_o) begin
        cpu_acc_t = $time;
        done      = 1'b1;
      end
      @(negedge clk);
      n++;
      if (n > TMO) abort_on_timeout("CPU request was never accepted");
    end
    cpu_req_i = '0;
    lat       = 1;
    while (!cpu_rsp_o.valid) begin
      @(negedge clk);
      lat++;
      if (lat > TMO) abort_on_timeout("CPU response never arrived");
    end
    err  = cpu_rsp_o.err;
    data = cpu_rsp_o.data;
  endtask

  task automatic dma_xfer(input logic wr, input logic [31:0] a, input logic [31:0] d,
                          input logic [3:0] s, output logic err, output logic [31:0] data);
    int  n;
    logic done;
    n    = 0;
    done = 1'b0;
    @(negedge clk);
    dma_req_i = '{valid: 1'b1, write: wr, addr: a, data: d, strb: s};
    while (!done) begin
      #1;
      if (dma_ready_o) begin
        dma_acc_t = $time;
        done      = 1'b1;
      end
      @(negedge clk);
      n++;
      if (n > TMO) abort_on_timeout("DMA request was never accepted");
    end
    dma_req_i = '0;
    n         = 0;
    while (!dma_rsp_o.valid) begin
      @(negedge clk);
      n++;
      if (n > TMO) abort_on_timeout("DMA response never arrived");
    end
    err  = dma_rsp_o.err;
    data = dma_rsp_o.data;
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic reset_test();
    int n;
    repeat (10) @(negedge clk);
    rst_i = 1'b0;
    // Both masters ask while the bus is still in reset
    cpu_req_i = '{valid: 1'b1, write: 1'b0, addr: 32'h0, data: 64'h0, strb: 8'h00};
    dma_req_i = '{valid: 1'b1, write: 1'b0, addr: 32'h8, data: 32'h0, strb: 4'h0};
    // Calibration pending alone, then auxiliary reset alone
    aux_rst_i = 1'b0;
    for (int i = 0; i < 10; i++) begin
      if (i == 5) begin
        aux_rst_i    = 1'b1;
        calib_done_i = 1'b1;
      end
      @(negedge clk);
      checks++;
      if (!bus_rst_o || !outputs_quiet()) begin
        errors++;
        $display("Bus reset dropped or an output was active while a reset source was active");
      end
    end
    cpu_req_i = '0;
    dma_req_i = '0;
    aux_rst_i = 1'b0;
    n = 0;
    while (bus_rst_o) begin
      checks++;
      if (!outputs_quiet()) begin
        errors++;
        $display("A valid or ready output was high during bus reset");
      end
      @(negedge clk);
      n++;
      if (n > TMO) abort_on_timeout("bus reset never released");
    end
    expect_eq("bus_rst_o hold cycles", 64'(n), 64'(HOLD));
  endtask

  task automatic cpu_mem_test();
    logic [31:0] a [6];
    logic [63:0] d;
    logic [63:0] rd;
    logic [7:0]  s;
    logic        err;
    int          lat;
    for (int i = 0; i < 6; i++) begin
      a[i]      = 32'(rand_bits(25)) << 3;
      d         = rand_bits(64);
      s         = 8'(rand_bits(8));
      mem_delay = i % 4;
      cpu_xfer(1'b1, a[i], d, s, err, rd, lat);
      expect_eq("cpu_rsp_o.err", 64'(err), 64'h0);
      expect_eq("mem_req_o.addr", 64'(mem_last.addr), 64'(a[i]));
      expect_eq("mem_req_o.strb", 64'(mem_last.strb), 64'(s));
      shadow[a[i] >> 3] = merge64(shadow_get(a[i] >> 3), d, s);
    end
    for (int i = 0; i < 6; i++) begin
      mem_delay = (i + 1) % 4;
      cpu_xfer(1'b0, a[i], 64'h0, 8'h00, err, rd, lat);
      expect_eq("cpu_rsp_o.err", 64'(err), 64'h0);
      expect_eq("mem_req_o.addr", 64'(mem_last.addr), 64'(a[i]));
      expect_eq("cpu_rsp_o.data", rd, shadow_get(a[i] >> 3));
    end
    last_dma = 1'b0;
  endtask

  task automatic sdc_test();
    logic [31:0] base;
    logic [63:0] d;
    logic [63:0] d2;
    logic [63:0] rd;
    logic [31:0] exp_lo;
    logic        err;
    int          lat;
    int          s0;
    base = fabric_pkg::SDC_BASE;
    d    = rand_bits(64);
    cpu_xfer(1'b1, base + 32'h10, d, 8'h06, err, rd, lat);
    expect_eq("cpu_rsp_o.err", 64'(err), 64'h0);
    expect_eq("sdc_req_o.addr", 64'(sdc_last.addr), 64'h10);
    expect_eq("sdc_req_o.data", 64'(sdc_last.data), 64'(d[31:0]));
    expect_eq("sdc_req_o.strb", 64'(sdc_last.strb), 64'h6);
    exp_lo = merge32(reg_init(4), d[31:0], 4'h6);
    d2 = rand_bits(64);
    cpu_xfer(1'b1, base + 32'h14, d2, 8'hf0, err, rd, lat);
    expect_eq("sdc_req_o.addr", 64'(sdc_last.addr), 64'h14);
    expect_eq("sdc_req_o.data", 64'(sdc_last.data), 64'(d2[63:32]));
    expect_eq("sdc_req_o.strb", 64'(sdc_last.strb), 64'hf);
    cpu_xfer(1'b0, base + 32'h10, 64'h0, 8'h00, err, rd, lat);
    expect_eq("cpu_rsp_o.data", rd, {2{exp_lo}});
    cpu_xfer(1'b0, base + 32'h14, 64'h0, 8'h00, err, rd, lat);
    expect_eq("cpu_rsp_o.data", rd, {2{d2[63:32]}});
    // Strobes on both lanes are rejected
    s0 = sdc_vld_cycles;
    cpu_xfer(1'b1, base + 32'h20, d, 8'h18, err, rd, lat);
    expect_eq("cpu_rsp_o.err", 64'(err), 64'h1);
    expect_eq("sdc_req_o.valid cycles", 64'(sdc_vld_cycles), 64'(s0));
    last_dma = 1'b0;
  endtask

  task automatic dma_test();
    logic [31:0] d;
    logic [31:0] rd;
    logic [63:0] w;
    logic        err;
    d = 32'(rand_bits(32));
    dma_xfer(1'b1, 32'h1004, d, 4'hf, err, rd);
    expect_eq("dma_rsp_o.err", 64'(err), 64'h0);
    expect_eq("mem_req_o.strb", 64'(mem_last.strb), 64'hf0);
    expect_eq("mem_req_o.data upper", 64'(mem_last.data[63:32]), 64'(d));
    shadow[32'h1004 >> 3] = merge64(shadow_get(32'h1004 >> 3), {2{d}}, 8'hf0);
    w = shadow_get(32'h1004 >> 3);
    dma_xfer(1'b0, 32'h1004, 32'h0, 4'h0, err, rd);
    expect_eq("dma_rsp_o.data upper", 64'(rd), 64'(w[63:32]));
    dma_xfer(1'b0, 32'h1000, 32'h0, 4'h0, err, rd);
    expect_eq("dma_rsp_o.data lower", 64'(rd), 64'(w[31:0]));
    last_dma = 1'b1;
  endtask

  task automatic contention_test();
    logic [63:0] dc;
    logic [31:0] dd;
    logic [63:0] rc;
    logic [31:0] rdd;
    logic [31:0] ca;
    logic [31:0] da;
    logic        ec;
    logic        ed;
    int          lat;
    for (int r = 0; r < 2; r++) begin
      dc        = rand_bits(64);
      dd        = 32'(rand_bits(32));
      ca        = 32'h2000 + 32'(r * 16);
      da        = 32'h3000 + 32'(r * 8);
      mem_delay = 1;
      fork
        cpu_xfer(1'b1, ca, dc, 8'hff, ec, rc, lat);
        dma_xfer(1'b1, da, dd, 4'hf, ed, rdd);
      join
      checks++;
      if ((cpu_acc_t < dma_acc_t) != last_dma) begin
        errors++;
        $display("Grant order wrong in contention round %0d", r);
      end
      expect_eq("cpu_rsp_o.err", 64'(ec), 64'h0);
      expect_eq("dma_rsp_o.err", 64'(ed), 64'h0);
      shadow[ca >> 3] = dc;
      shadow[da >> 3] = merge64(shadow_get(da >> 3), {2{dd}}, 8'h0f);
      // CPU served last, so the next round starts with DMA
      dma_xfer(1'b0, da, 32'h0, 4'h0, ed, rdd);
      expect_eq("dma_rsp_o.data", 64'(rdd), 64'(dd));
      cpu_xfer(1'b0, ca, 64'h0, 8'h00, ec, rc, lat);
      expect_eq("cpu_rsp_o.data", rc, shadow_get(ca >> 3));
      last_dma = 1'b0;
    end
  endtask

  task automatic decode_test();
    logic [63:0] rd;
    logic        err;
    int          lat;
    int          m0;
    int          s0;
    m0 = mem_vld_cycles;
    s0 = sdc_vld_cycles;
    cpu_xfer(1'b0, 32'h2000_0000, 64'h0, 8'h00, err, rd, lat);
    expect_eq("cpu_rsp_o.err", 64'(err), 64'h1);
    expect_eq("decode error latency", 64'(lat), 64'h2);
    expect_eq("mem_req_o.valid cycles", 64'(mem_vld_cycles), 64'(m0));
    expect_eq("sdc_req_o.valid cycles", 64'(sdc_vld_cycles), 64'(s0));
  endtask

  initial begin
    rst_i        = 1'b1;
    calib_done_i = 1'b0;
    aux_rst_i    = 1'b1;
    cpu_req_i    = '0;
    dma_req_i    = '0;
    mem_ready_i  = 1'b0;
    mem_rsp_i    = '0;
    sdc_ready_i  = 1'b0;
    sdc_rsp_i    = '0;
    for (int i = 0; i < 64; i++) begin
      sdc_regs[i] = reg_init(i);
    end
    reset_test();
    cpu_mem_test();
    sdc_test();
    dma_test();
    contention_test();
    decode_test();
    finish_run();
  end

endmodule
